/* hdl/cpu6502_pkg.sv */
package cpu6502_pkg;

    typedef logic [7:0]  byte_t;  // Data byte
    typedef logic [15:0] addr_t;  // Memory address or program counter

    // Cycle states of one instruction
    typedef enum logic [2:0]
    {
        st_fetch        = 3'd0,  // Opcode request and write back of the previous instruction
        st_operand      = 3'd1,  // Second byte request
        st_zeropage     = 3'd2,  // Zero-page read or write
        st_address_high = 3'd3,  // JMP high byte request
        st_branch_low   = 3'd4,  // New PCL for a taken branch
        st_branch_high  = 3'd5   // Page fixup of PCH
    } state_t;

    typedef struct packed
    {
        logic n;  // Negative
        logic v;  // Overflow
        logic z;  // Zero
        logic c;  // Carry
    } flags_t;

    // Control word from the decoder
    typedef struct packed
    {
        struct packed
        {
            logic increment;    // PC + 1
            logic branch_low;   // PCL from branch adder
            logic branch_high;  // PCH fixup after a page crossing
            logic vector;       // PC from the last two bytes read
        } pc;
        struct packed
        {
            logic pc;        // Address is PC
            logic zeropage;  // Address is 00 and data byte
        } addr;
        struct packed
        {
            logic enable;  // Write A to memory
        } write;
        struct packed
        {
            logic data_in;  // Data byte onto DB
            logic alu;      // ALU result onto DB
            logic a;        // A onto DB
            logic count;    // Counter result onto DB
        } db;
        struct packed
        {
            logic x;    // Counter input from X
            logic y;    // Counter input from Y
            logic inc;  // Count up
            logic dec;  // Count down
        } count;
        struct packed
        {
            logic nz;     // N and Z from DB
            logic alu_c;  // C from ALU carry
            logic alu_v;  // V from ALU overflow
            logic ir5_c;  // C from opcode bit 5
            logic ir5_v;  // V cleared by CLV
        } flag;
        struct packed
        {
            logic a;
            logic x;
            logic y;
        } load;  // Register loads from DB
    } control_t;

    typedef struct packed
    {
        addr_t address;
        byte_t data;   // Write data
        logic  write;
    } bus_t;

    typedef struct packed
    {
        byte_t a;
        byte_t x;
        byte_t y;
        byte_t pcl;  // Low byte of PC for the branch adder
    } regs_t;

endpackage

/* hdl/cpu6502_alu.sv */
`timescale 1ns/1ps

module cpu6502_alu
(
    input  cpu6502_pkg::byte_t a,
    input  cpu6502_pkg::byte_t b,
    input  logic               carry_in,
    input  logic [2:0]         op,         // ORA AND EOR ADC STA LDA CMP SBC
    output cpu6502_pkg::byte_t result,
    output logic               carry_out,
    output logic               overflow
);
    import cpu6502_pkg::*;

    byte_t      addend;  // Second operand after complement
    logic       carry;
    logic [8:0] sum;

    assign addend = op[2] ? ~b : b;        // CMP and SBC subtract
    assign carry  = carry_in | ~op[0];     // CMP always starts with carry set
    assign sum    = {1'b0, a} + {1'b0, addend} + 9'(carry);

    always_comb
    begin
        case (op)
            3'd0:    result = a | b;     // ORA
            3'd1:    result = a & b;     // AND
            3'd2:    result = a ^ b;     // EOR
            3'd3:    result = sum[7:0];  // ADC
            3'd5:    result = b;         // LDA
            3'd6:    result = sum[7:0];  // CMP
            3'd7:    result = sum[7:0];  // SBC
            default: result = 8'h00;     // STA has no result
        endcase
    end

    // Signed overflow when both inputs agree in sign and the result does not
    assign overflow  = (a[7] ^ result[7]) & (addend[7] ^ result[7]);
    assign carry_out = sum[8];

endmodule

/* hdl/cpu6502_decode.sv */
`timescale 1ns/1ps

module cpu6502_decode
(
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  enable,
    input  cpu6502_pkg::byte_t    data_in,
    input  cpu6502_pkg::byte_t    data_latch,
    input  cpu6502_pkg::flags_t   flags,
    input  logic                  branch_cross,
    output cpu6502_pkg::control_t control,
    output cpu6502_pkg::state_t   state,
    output cpu6502_pkg::byte_t    opcode
);
    import cpu6502_pkg::*;

    byte_t  opcode_reg;  // Opcode of the instruction in flight
    state_t next_state;

    // Opcode byte is on the bus during st_operand and held from then on
    assign opcode = (state == st_operand) ? data_latch : opcode_reg;

    // Opcode classes
    wire logic op_alu_imm = (opcode ==? 8'b???_010_01) && (opcode[7:5] != 3'b100);
    wire logic op_alu_zp  = opcode ==? 8'b???_001_01;  // Includes STA $00
    wire logic op_sta     = opcode == 8'h85;
    wire logic op_alu     = op_alu_imm | (op_alu_zp & ~op_sta);
    wire logic op_cmp     = opcode[7:5] == 3'b110;
    wire logic op_adc_sbc = opcode[6:5] == 2'b11;      // ADC or SBC
    wire logic op_ldx     = opcode == 8'hA2;
    wire logic op_ldy     = opcode == 8'hA0;
    wire logic op_tax     = opcode == 8'hAA;
    wire logic op_tay     = opcode == 8'hA8;
    wire logic op_txa     = opcode == 8'h8A;
    wire logic op_tya     = opcode == 8'h98;
    wire logic op_inx     = opcode == 8'hE8;
    wire logic op_iny     = opcode == 8'hC8;
    wire logic op_dex     = opcode == 8'hCA;
    wire logic op_dey     = opcode == 8'h88;
    wire logic op_clc_sec = opcode ==? 8'b00?_110_00;
    wire logic op_clv     = opcode == 8'hB8;
    wire logic op_branch  = opcode ==? 8'b???_100_00;  // BPL BMI BVC BVS BCC BCS BNE BEQ
    wire logic op_jmp     = opcode == 8'h4C;

    wire logic op_count = op_txa | op_tya | op_inx | op_iny | op_dex | op_dey;
    wire logic op_load_x = op_ldx | op_tax | op_inx | op_dex;
    wire logic op_load_y = op_ldy | op_tay | op_iny | op_dey;
    wire logic op_load_a = (op_alu & ~op_cmp) | op_txa | op_tya;
    wire logic op_operand = op_alu_imm | op_alu_zp | op_ldx | op_ldy | op_branch | op_jmp;

    // Opcode bits 7..6 pick the flag and bit 5 the value that takes the branch
    wire logic [3:0] branch_flags = {flags.z, flags.c, flags.v, flags.n};
    wire logic branch_taken = branch_flags[opcode[7:6]] == opcode[5];

    always_comb
    begin
        control    = '0;
        next_state = st_fetch;
        case (state)
            st_fetch:
            begin
                next_state           = st_operand;
                control.addr.pc      = 1'b1;
                control.pc.increment = 1'b1;
                control.pc.vector    = op_jmp;  // JMP target completes here

                // Write back of the previous instruction
                control.db.data_in   = op_ldx | op_ldy;
                control.db.alu       = op_alu;
                control.db.a         = op_tax | op_tay;
                control.db.count     = op_count;
                control.count.x      = op_txa | op_inx | op_dex;
                control.count.y      = op_tya | op_iny | op_dey;
                control.count.inc    = op_inx | op_iny;
                control.count.dec    = op_dex | op_dey;
                control.flag.nz      = op_alu | op_ldx | op_ldy | op_tax | op_tay | op_count;
                control.flag.alu_c   = op_alu & (op_adc_sbc | op_cmp);
                control.flag.alu_v   = op_alu & op_adc_sbc;
                control.flag.ir5_c   = op_clc_sec;
                control.flag.ir5_v   = op_clv;
                control.load.a       = op_load_a;
                control.load.x       = op_load_x;
                control.load.y       = op_load_y;
            end
            st_operand:
            begin
                control.addr.pc      = 1'b1;
                control.pc.increment = op_operand;  // Implied ops reread the same byte
                if (op_alu_zp)
                    next_state = st_zeropage;
                else if (op_jmp)
                    next_state = st_address_high;
                else if (op_branch && branch_taken)
                    next_state = st_branch_low;
            end
            st_zeropage:
            begin
                control.addr.zeropage = 1'b1;
                control.write.enable  = op_sta;
            end
            st_address_high:
            begin
                control.addr.pc = 1'b1;  // High byte arrives in the next fetch
            end
            st_branch_low:
            begin
                control.addr.pc       = 1'b1;  // Dummy read of the next opcode
                control.pc.branch_low = 1'b1;
                if (branch_cross)
                    next_state = st_branch_high;
            end
            st_branch_high:
            begin
                control.addr.pc        = 1'b1;  // Dummy read in the old page
                control.pc.branch_high = 1'b1;
            end
            default:
            begin
                next_state = st_fetch;
            end
        endcase
    end

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            state      <= st_fetch;
            opcode_reg <= 8'hEA;  // NOP so the first fetch writes nothing back
        end
        else if (enable)
        begin
            state <= next_state;
            if (state == st_operand)
                opcode_reg <= data_in;
        end
    end

    state_legal : assert property (@(posedge clock) disable iff (reset)
        state inside {st_fetch, st_operand, st_zeropage, st_address_high,
                      st_branch_low, st_branch_high});

    write_in_zeropage : assert property (@(posedge clock) disable iff (reset)
        control.write.enable |-> state == st_zeropage);

    // Page fixup is only reached from the low byte update
    fixup_after_low : assert property (@(posedge clock) disable iff (reset)
        enable && state != st_branch_low |=> state != st_branch_high);

endmodule

/* hdl/cpu6502_execute.sv */
`timescale 1ns/1ps

module cpu6502_execute
(
    input  cpu6502_pkg::control_t control,
    input  cpu6502_pkg::byte_t    opcode,
    input  cpu6502_pkg::regs_t    regs,
    input  cpu6502_pkg::flags_t   flags,
    input  cpu6502_pkg::byte_t    data_latch,
    output cpu6502_pkg::byte_t    db,
    output logic                  alu_carry,
    output logic                  alu_overflow,
    output cpu6502_pkg::byte_t    branch_low,
    output logic                  branch_cross,
    output logic                  branch_back
);
    import cpu6502_pkg::*;

    byte_t      alu_result;
    byte_t      count_in;
    byte_t      count_out;
    logic [8:0] branch_sum;  // PCL plus offset with carry

    // A against the operand byte
    cpu6502_alu alu_i
    (
        .a         (regs.a),
        .b         (data_latch),
        .carry_in  (flags.c),
        .op        (opcode[7:5]),
        .result    (alu_result),
        .carry_out (alu_carry),
        .overflow  (alu_overflow)
    );

    // Counter for transfers and increment or decrement
    assign count_in  = control.count.x ? regs.x :
                       control.count.y ? regs.y : data_latch;
    assign count_out = count_in + {8{control.count.dec}} + 8'(control.count.inc);

    // Internal data bus
    assign db = (control.db.data_in ? data_latch : '0)
              | (control.db.alu     ? alu_result : '0)
              | (control.db.a       ? regs.a     : '0)
              | (control.db.count   ? count_out  : '0);

    // Branch target low byte
    assign branch_sum   = {1'b0, regs.pcl} + {1'b0, data_latch};
    assign branch_low   = branch_sum[7:0];
    assign branch_cross = branch_sum[8] ^ data_latch[7];  // Carry forward or borrow backward
    assign branch_back  = data_latch[7];                  // Negative offset

endmodule

/* hdl/cpu6502_result.sv */
`timescale 1ns/1ps

module cpu6502_result
#(
    parameter cpu6502_pkg::addr_t RESET_PC = 16'h0200
)
(
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  enable,
    input  cpu6502_pkg::byte_t    data_in,
    input  cpu6502_pkg::control_t control,
    input  cpu6502_pkg::byte_t    opcode,
    input  cpu6502_pkg::byte_t    db,
    input  logic                  alu_carry,
    input  logic                  alu_overflow,
    input  cpu6502_pkg::byte_t    branch_low,
    input  logic                  branch_back,
    output cpu6502_pkg::regs_t    regs,
    output cpu6502_pkg::flags_t   flags,
    output cpu6502_pkg::byte_t    data_latch,
    output cpu6502_pkg::bus_t     bus
);
    import cpu6502_pkg::*;

    byte_t  a_reg;
    byte_t  x_reg;
    byte_t  y_reg;
    addr_t  pc;
    addr_t  pc_base;     // PC or JMP vector for this cycle
    addr_t  next_pc;
    flags_t next_flags;
    byte_t  data_prev;   // Byte seen one cycle earlier
    byte_t  write_data;  // Last byte written
    logic   wrote;       // Previous enabled cycle was a write
    logic   back;        // Branch direction kept for the fixup

    // Memory holds data_in between enabled edges
    assign data_latch = wrote ? write_data : data_in;

    assign regs = {a_reg, x_reg, y_reg, pc[7:0]};

    always_comb
    begin
        pc_base = control.pc.vector ? {data_latch, data_prev} : pc;  // High byte now, low before
        if (control.pc.branch_low)
            next_pc = {pc[15:8], branch_low};
        else if (control.pc.branch_high)
            next_pc = {pc[15:8] + (back ? 8'hFF : 8'h01), pc[7:0]};
        else
            next_pc = pc_base + addr_t'(control.pc.increment);
    end

    always_comb
    begin
        next_flags = flags;
        if (control.flag.nz)
        begin
            next_flags.n = db[7];
            next_flags.z = db == 8'h00;
        end
        if (control.flag.alu_c)
            next_flags.c = alu_carry;
        else if (control.flag.ir5_c)
            next_flags.c = opcode[5];  // CLC 18 or SEC 38
        if (control.flag.alu_v)
            next_flags.v = alu_overflow;
        else if (control.flag.ir5_v)
            next_flags.v = ~opcode[5];  // CLV has bit 5 set
    end

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            pc    <= RESET_PC;
            a_reg <= '0;
            x_reg <= '0;
            y_reg <= '0;
            flags <= '0;
            wrote <= 1'b0;
        end
        else if (enable)
        begin
            pc    <= next_pc;
            flags <= next_flags;
            wrote <= control.write.enable;
            if (control.load.a)
                a_reg <= db;
            if (control.load.x)
                x_reg <= db;
            if (control.load.y)
                y_reg <= db;
        end
    end

    // Byte history and branch direction
    always_ff @(posedge clock)
    begin
        if (enable)
        begin
            data_prev <= data_latch;
            if (control.write.enable)
                write_data <= bus.data;
            if (control.pc.branch_low)
                back <= branch_back;
        end
    end

    // Bus request
    assign bus.address = (control.addr.pc       ? pc_base              : '0)
                       | (control.addr.zeropage ? {8'h00, data_latch} : '0);
    assign bus.data    = a_reg;  // STA is the only store
    assign bus.write   = control.write.enable;

    pc_held_on_stall : assert property (@(posedge clock) disable iff (reset)
        !enable |=> $stable(pc));

endmodule

/* hdl/cpu6502.sv */
`timescale 1ns/1ps

module cpu6502
#(
    parameter cpu6502_pkg::addr_t RESET_PC = 16'h0200
)
(
    input  logic               clock,
    input  logic               reset,
    input  logic               enable,        // Stall when low
    input  cpu6502_pkg::byte_t data_in,
    output cpu6502_pkg::addr_t address,
    output cpu6502_pkg::byte_t data_out,
    output logic               write_enable,
    output logic               sync          // Opcode fetch cycle
);
    import cpu6502_pkg::*;

    control_t control;
    state_t   state;
    byte_t    opcode;
    regs_t    regs;
    flags_t   flags;
    byte_t    data_latch;
    byte_t    db;
    logic     alu_carry;
    logic     alu_overflow;
    byte_t    branch_low;
    logic     branch_cross;
    logic     branch_back;
    bus_t     bus;

    cpu6502_decode decode_i
    (
        .clock        (clock),
        .reset        (reset),
        .enable       (enable),
        .data_in      (data_in),
        .data_latch   (data_latch),
        .flags        (flags),
        .branch_cross (branch_cross),
        .control      (control),
        .state        (state),
        .opcode       (opcode)
    );

    cpu6502_execute execute_i
    (
        .control      (control),
        .opcode       (opcode),
        .regs         (regs),
        .flags        (flags),
        .data_latch   (data_latch),
        .db           (db),
        .alu_carry    (alu_carry),
        .alu_overflow (alu_overflow),
        .branch_low   (branch_low),
        .branch_cross (branch_cross),
        .branch_back  (branch_back)
    );

    cpu6502_result #(.RESET_PC(RESET_PC)) result_i
    (
        .clock        (clock),
        .reset        (reset),
        .enable       (enable),
        .data_in      (data_in),
        .control      (control),
        .opcode       (opcode),
        .db           (db),
        .alu_carry    (alu_carry),
        .alu_overflow (alu_overflow),
        .branch_low   (branch_low),
        .branch_back  (branch_back),
        .regs         (regs),
        .flags        (flags),
        .data_latch   (data_latch),
        .bus          (bus)
    );

    assign address      = bus.address;
    assign data_out     = bus.data;
    assign write_enable = bus.write;
    assign sync         = state == st_fetch;

endmodule

/* tb/cpu6502_model.svh */
`ifndef CPU6502_MODEL_SVH
`define CPU6502_MODEL_SVH

// Instruction-level reference of the reduced 6502 core and its random program source

// Supported opcodes with STA listed four times so stores come often
localparam logic [40*8-1:0] OPCODE_TABLE = {
    8'h09, 8'h29, 8'h49, 8'h69, 8'hA9, 8'hC9, 8'hE9,         // Immediate ALU
    8'h05, 8'h25, 8'h45, 8'h65, 8'hA5, 8'hC5, 8'hE5,         // Zero-page ALU
    8'h85, 8'h85, 8'h85, 8'h85,                              // STA zero page
    8'hA2, 8'hA0, 8'hAA, 8'hA8, 8'h8A, 8'h98,                // Loads and transfers
    8'hE8, 8'hC8, 8'hCA, 8'h88, 8'h18, 8'h38, 8'hB8,         // Counters and flag ops
    8'h10, 8'h30, 8'h50, 8'h70, 8'h90, 8'hB0, 8'hD0, 8'hF0,  // Branches
    8'h4C                                                    // JMP absolute
};

logic [7:0]  model_memory [0:65535];  // Own copy that STA updates
logic [15:0] model_pc;
logic [7:0]  model_a;
logic [7:0]  model_x;
logic [7:0]  model_y;
logic        model_n;
logic        model_v;
logic        model_z;
logic        model_c;
int          expected_cycles;         // Enabled cycles of the last stepped instruction
logic        write_pending = 1'b0;    // STA store not yet seen on the bus
logic [15:0] write_address;
logic [7:0]  write_value;

task automatic put_byte(inout logic [15:0] where, inout int room, input logic [7:0] value);
    if (room > 0)
    begin
        memory[where]       = value;
        model_memory[where] = value;
        where               = where + 16'd1;
        room                = room - 1;
    end
endtask

// Mostly forward offsets, and backward ones skip at least 32 bytes
function automatic logic [7:0] branch_offset();
    if ($urandom_range(4, 0) == 0)
        return 8'($urandom_range(224, 128));
    return 8'($urandom_range(127, 0));
endfunction

// One instruction stream round all 64 KiB, starting at the first fetch address
task automatic generate_program(input logic [15:0] start);
    logic [15:0] where;
    logic [15:0] target;
    logic [7:0]  opcode;
    int          room;
    where = start;
    room  = 65536;
    while (room > 0)
    begin
        opcode = OPCODE_TABLE[8 * $urandom_range(39, 0) +: 8];
        put_byte(where, room, opcode);
        case (opcode)
            8'hAA, 8'hA8, 8'h8A, 8'h98, 8'hE8, 8'hC8, 8'hCA, 8'h88, 8'h18, 8'h38, 8'hB8:
                ;  // Implied without operand
            8'h4C:
            begin
                target = where + 16'd2 + 16'($urandom_range(300, 0));  // Forward jump only
                put_byte(where, room, target[7:0]);
                put_byte(where, room, target[15:8]);
            end
            8'h10, 8'h30, 8'h50, 8'h70, 8'h90, 8'hB0, 8'hD0, 8'hF0:
                put_byte(where, room, branch_offset());
            default:
                put_byte(where, room, 8'($urandom_range(255, 0)));
        endcase
    end
endtask

task automatic reset_model(input logic [15:0] start);
    model_pc      = start;
    model_a       = 8'h00;
    model_x       = 8'h00;
    model_y       = 8'h00;
    {model_n, model_v, model_z, model_c} = 4'b0000;
    write_pending = 1'b0;
endtask

task automatic update_nz(input logic [7:0] value);
    model_n = value[7];
    model_z = value == 8'h00;
endtask

// aaa field of the 6502 group one opcodes
task automatic execute_alu(input logic [2:0] operation, input logic [7:0] m);
    logic [8:0] sum;
    logic [7:0] result;
    case (operation)
        3'd0: result = model_a | m;
        3'd1: result = model_a & m;
        3'd2: result = model_a ^ m;
        3'd5: result = m;
        3'd3:
        begin
            sum     = model_a + m + model_c;
            model_v = ~(model_a[7] ^ m[7]) & (model_a[7] ^ sum[7]);
            model_c = sum[8];
            result  = sum[7:0];
        end
        3'd6:
        begin
            model_c = model_a >= m;
            result  = model_a - m;
        end
        default:
        begin
            sum     = {1'b0, model_a} - {1'b0, m} - (model_c ? 9'd0 : 9'd1);  // SBC
            model_v = (model_a[7] ^ m[7]) & (model_a[7] ^ sum[7]);
            model_c = ~sum[8];       // No borrow
            result  = sum[7:0];
        end
    endcase
    update_nz(result);
    if (operation != 3'd6)
        model_a = result;  // CMP leaves A alone
endtask

// Runs the instruction at the model PC and records its cycle count and its store
task automatic step_instruction();
    logic [7:0]  opcode;
    logic [7:0]  operand;
    logic [15:0] next_pc;
    logic [15:0] target;
    logic        flag;
    opcode          = model_memory[model_pc];
    operand         = model_memory[model_pc + 16'd1];
    next_pc         = model_pc + 16'd2;  // Two bytes unless changed below
    expected_cycles = 2;
    case (opcode)
        8'h09, 8'h29, 8'h49, 8'h69, 8'hA9, 8'hC9, 8'hE9:
            execute_alu(opcode[7:5], operand);
        8'h05, 8'h25, 8'h45, 8'h65, 8'hA5, 8'hC5, 8'hE5:
        begin
            execute_alu(opcode[7:5], model_memory[{8'h00, operand}]);
            expected_cycles = 3;
        end
        8'h85:
        begin
            write_pending               = 1'b1;
            write_address               = {8'h00, operand};
            write_value                 = model_a;
            model_memory[write_address] = model_a;
            expected_cycles             = 3;
        end
        8'hA2:
        begin
            model_x = operand;
            update_nz(model_x);
        end
        8'hA0:
        begin
            model_y = operand;
            update_nz(model_y);
        end
        8'hAA, 8'hE8, 8'hCA:  // TAX INX DEX
        begin
            case (opcode)
                8'hAA:   model_x = model_a;
                8'hE8:   model_x = model_x + 8'd1;
                default: model_x = model_x - 8'd1;
            endcase
            update_nz(model_x);
            next_pc = model_pc + 16'd1;
        end
        8'hA8, 8'hC8, 8'h88:  // TAY INY DEY
        begin
            case (opcode)
                8'hA8:   model_y = model_a;
                8'hC8:   model_y = model_y + 8'd1;
                default: model_y = model_y - 8'd1;
            endcase
            update_nz(model_y);
            next_pc = model_pc + 16'd1;
        end
        8'h8A, 8'h98:  // TXA TYA
        begin
            model_a = (opcode == 8'h8A) ? model_x : model_y;
            update_nz(model_a);
            next_pc = model_pc + 16'd1;
        end
        8'h18, 8'h38, 8'hB8:  // CLC SEC CLV
        begin
            if (opcode == 8'hB8)
                model_v = 1'b0;
            else
                model_c = opcode == 8'h38;
            next_pc = model_pc + 16'd1;
        end
        8'h10, 8'h30, 8'h50, 8'h70, 8'h90, 8'hB0, 8'hD0, 8'hF0:
        begin
            case (opcode[7:6])  // Flag tested by the branch
                2'd0:    flag = model_n;
                2'd1:    flag = model_v;
                2'd2:    flag = model_c;
                default: flag = model_z;
            endcase
            if (flag == opcode[5])  // Bit 5 set branches on a set flag
            begin
                target          = next_pc + {{8{operand[7]}}, operand};
                expected_cycles = (target[15:8] == next_pc[15:8]) ? 3 : 4;
                next_pc         = target;
            end
        end
        8'h4C:
        begin
            next_pc         = {model_memory[model_pc + 16'd2], operand};
            expected_cycles = 3;
        end
        default:
            next_pc = model_pc + 16'd1;  // Anything else is a one-byte no-op
    endcase
    model_pc = next_pc;
endtask

`endif

/* tb/cpu6502_tb.sv */
`timescale 1ns/1ps

module cpu6502_tb;

    localparam logic [15:0] RESET_PC         = 16'h0400;
    localparam int          NUM_INSTRUCTIONS = 3000;
    localparam int          FETCH_TIMEOUT    = 200;  // Clock cycles from one fetch to the next

    logic        clock = 1'b0;
    logic        reset;
    logic        enable;
    logic [7:0]  data_in;
    logic [15:0] address;
    logic [7:0]  data_out;
    logic        write_enable;
    logic        sync;

    logic [7:0]  memory [0:65535];  // Memory behind the DUT bus

    int   error_count       = 0;
    int   check_count       = 0;
    int   instruction_count = 0;
    int   cycle_count       = 0;     // Enabled cycles since the last fetch
    logic reset_checked     = 1'b0;
    logic last_valid        = 1'b0;  // Previous sample taken out of reset
    logic last_enable;
    logic [15:0] last_address;
    logic last_write;
    logic last_sync;

    `include "cpu6502_model.svh"

    cpu6502 #(.RESET_PC(RESET_PC)) cpu6502_i
    (
        .clock        (clock),
        .reset        (reset),
        .enable       (enable),
        .data_in      (data_in),
        .address      (address),
        .data_out     (data_out),
        .write_enable (write_enable),
        .sync         (sync)
    );

    always #4 clock = ~clock;  // 8 ns period

    always @(posedge clock)
        enable <= $urandom_range(3, 0) != 0;  // High about 3 cycles in 4

    // Synchronous memory that holds its data across stalls
    always @(posedge clock)
    begin
        if (!reset && enable)
        begin
            if (write_enable)
            begin
                memory[address] <= data_out;
                data_in         <= data_out;
            end
            else
                data_in <= memory[address];
        end
    end

    task automatic compare_value(input string name, input logic [15:0] expected,
                                 input logic [15:0] actual);
        check_count++;
        assert (actual === expected)
        else
        begin
            error_count++;
            $display("[ERROR] %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    task automatic require(input logic condition, input string text);
        check_count++;
        assert (condition === 1'b1)
        else
        begin
            error_count++;
            $display("[ERROR] %s", text);
        end
    endtask

    // Outputs sampled mid-cycle away from the driving edge
    always @(negedge clock)
    begin
        if (!reset)
        begin
            if (!reset_checked)
            begin
                compare_value("reset_write_enable", 16'd0, write_enable);
                compare_value("reset_sync", 16'd1, sync);
                compare_value("reset_address", RESET_PC, address);
                reset_checked = 1'b1;
            end
            if (last_valid && !last_enable)  // Last edge was stalled
            begin
                compare_value("stall_address", last_address, address);
                compare_value("stall_write_enable", last_write, write_enable);
                compare_value("stall_sync", last_sync, sync);
            end
            if (enable)
            begin
                if (write_enable)
                begin
                    require(write_pending, $sformatf("write to %0h outside an STA", address));
                    if (write_pending)
                    begin
                        compare_value("store_address", write_address, address);
                        compare_value("store_data", write_value, data_out);
                        write_pending = 1'b0;
                    end
                end
                if (sync)
                begin
                    if (instruction_count > 0)
                    begin
                        compare_value("instruction_cycles", expected_cycles, cycle_count);
                        require(!write_pending, "STA instruction ended without a write");
                    end
                    compare_value("fetch_address", model_pc, address);
                    step_instruction();
                    instruction_count++;
                    cycle_count = 0;
                end
                cycle_count++;
            end
            last_valid   = 1'b1;
            last_enable  = enable;
            last_address = address;
            last_write   = write_enable;
            last_sync    = sync;
        end
    end

    task automatic wait_for_fetch();
        int start;
        int waited;
        start  = instruction_count;
        waited = 0;
        while (instruction_count == start && waited < FETCH_TIMEOUT)
        begin
            @(posedge clock);
            waited++;
        end
        if (instruction_count == start)
            require(1'b0, $sformatf("no instruction fetch within %0d cycles", FETCH_TIMEOUT));
    endtask

    initial
    begin
        void'($urandom(69));
        reset   = 1'b1;
        enable  = 1'b0;
        data_in = 8'h00;
        generate_program(RESET_PC);
        reset_model(RESET_PC);
        repeat (2) @(posedge clock);
        reset <= 1'b0;
        while (instruction_count < NUM_INSTRUCTIONS && error_count == 0)
            wait_for_fetch();
        $display("Instructions %0d, checks %0d, errors %0d",
                 instruction_count, check_count, error_count);
        if (error_count == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

/* cpu6502.f */
+incdir+tb
hdl/cpu6502_pkg.sv
hdl/cpu6502_alu.sv
hdl/cpu6502_decode.sv
hdl/cpu6502_execute.sv
hdl/cpu6502_result.sv
hdl/cpu6502.sv
tb/cpu6502_tb.sv

/* Bender.yml */
package:
  name: cpu6502

sources:
  - hdl/cpu6502_pkg.sv
  - hdl/cpu6502_alu.sv
  - hdl/cpu6502_decode.sv
  - hdl/cpu6502_execute.sv
  - hdl/cpu6502_result.sv
  - hdl/cpu6502.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/cpu6502_tb.sv
